//--- source/mips_debug_cfg.svh
`ifndef MIPS_DEBUG_CFG_SVH
`define MIPS_DEBUG_CFG_SVH

//////////////////////////////////////////////////////////////////////
// datapath sizes
//////////////////////////////////////////////////////////////////////

// instruction and register word
`define DATA_LEN 32

// word address into instruction memory, 256 words
`define ADDR_LEN 8

// architectural registers
`define NUM_REGS 32

//////////////////////////////////////////////////////////////////////
// serial line
//////////////////////////////////////////////////////////////////////

// clocks per bit, kept small for short simulations
`define UART_CLKS_PER_BIT 16

`endif

//--- source/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// primary opcode field
	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_BEQ   = 6'd4,
		OP_ADDI  = 6'd8,
		OP_HALT  = 6'd63
	} opcode_t;

	// function field of r-type words
	typedef enum logic [5:0] {
		FN_ADD = 6'd32,
		FN_SUB = 6'd34
	} funct_t;

	// one instruction word, read as r-format or i-format
	typedef union packed {
		struct packed {
			opcode_t    op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			funct_t     funct;
		} r;
		struct packed {
			opcode_t     op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
	} instr_t;

	// debug unit sequencing
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		RUN,
		SEND_PC,
		SEND_REG,
		WAIT_TX
	} dbg_state_t;

endpackage

`default_nettype wire

//--- source/uart_rx.sv
`default_nettype none

`include "mips_debug_cfg.svh"

module uart_rx (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx_bit,
	output logic [7:0] rx_data,
	output logic       rx_done
);

	localparam int TICK_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_CLKS_PER_BIT - 1);
	localparam logic [TICK_W-1:0] HALF_TICK = TICK_W'(`UART_CLKS_PER_BIT / 2 - 1);

	// receiver states
	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA  = 2'd2;
	localparam logic [1:0] S_STOP  = 2'd3;

	logic [1:0]        state;
	logic [TICK_W-1:0] tick_cnt;
	logic [2:0]        bit_idx;
	logic [7:0]        shift;
	logic              rx_meta;
	logic              rx_sync;

	// two flops against the asynchronous line
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_bit;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= S_IDLE;
			tick_cnt <= '0;
			bit_idx  <= '0;
			rx_done  <= 1'b0;
		end else begin
			rx_done  <= 1'b0;
			tick_cnt <= tick_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					tick_cnt <= '0;
					// falling edge of the start bit
					if (!rx_sync) begin
						state <= S_START;
					end
				end
				S_START: begin
					// still low at half a bit, so a real start bit
					if (tick_cnt == HALF_TICK) begin
						tick_cnt <= '0;
						bit_idx  <= '0;
						state    <= rx_sync ? S_IDLE : S_DATA;
					end
				end
				S_DATA: begin
					if (tick_cnt == LAST_TICK) begin
						// lsb arrives first
						shift   <= {rx_sync, shift[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= S_STOP;
						end
					end
				end
				default: begin
					if (tick_cnt == LAST_TICK) begin
						// framing error drops the byte
						if (rx_sync) begin
							rx_data <= shift;
							rx_done <= 1'b1;
						end
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	rx_done_pulse: assert property (@(posedge clk) disable iff (reset)
		rx_done |=> !rx_done);

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`default_nettype none

`include "mips_debug_cfg.svh"

module uart_tx (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx_bit,
	output logic       tx_done
);

	localparam int TICK_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_CLKS_PER_BIT - 1);

	// stop, data, start; bit 0 is on the line
	logic [9:0]        frame;
	logic [TICK_W-1:0] tick_cnt;
	logic [3:0]        bit_idx;
	logic              busy;

	// line idles high
	assign tx_bit = busy ? frame[0] : 1'b1;

	// last cycle of the stop bit
	assign tx_done = busy && (bit_idx == 4'd9) && (tick_cnt == LAST_TICK);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy     <= 1'b0;
			tick_cnt <= '0;
			bit_idx  <= '0;
		end else if (!busy) begin
			tick_cnt <= '0;
			bit_idx  <= '0;
			if (tx_start) begin
				busy <= 1'b1;
			end
		end else if (tick_cnt == LAST_TICK) begin
			tick_cnt <= '0;
			bit_idx  <= bit_idx + 1'b1;
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;
			end
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// payload shifter
	always_ff @(posedge clk) begin
		if (!busy && tx_start) begin
			frame <= {1'b1, tx_data, 1'b0};
		end else if (busy && tick_cnt == LAST_TICK) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

	no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
		tx_start |-> !busy);

endmodule

`default_nettype wire

//--- source/debug_unit.sv
`default_nettype none

`include "mips_debug_cfg.svh"

module debug_unit import mips_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [7:0]           rx_data,
	input  logic                 rx_done,
	input  logic                 tx_done,
	input  logic                 halt,
	input  logic [7:0]           pc,
	input  logic [7:0]           reg1,
	output logic                 tx_start,
	output logic [7:0]           tx_data,
	output logic                 mem_we,
	output logic [`ADDR_LEN-1:0] mem_addr,
	output logic [`DATA_LEN-1:0] mem_wdata,
	output logic                 run,
	output logic                 core_clear
);

	dbg_state_t           state;
	logic [7:0]           words_left;
	logic [1:0]           byte_cnt;
	logic                 reg_sent;
	logic [`DATA_LEN-1:0] word_sr;

	// the assembled word goes straight to memory
	assign mem_wdata = word_sr;

	//////////////////////////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			words_left <= '0;
			byte_cnt   <= '0;
			reg_sent   <= 1'b0;
			mem_we     <= 1'b0;
			mem_addr   <= '0;
			run        <= 1'b0;
			core_clear <= 1'b0;
			tx_start   <= 1'b0;
		end else begin
			// single-cycle strobes
			mem_we     <= 1'b0;
			core_clear <= 1'b0;
			tx_start   <= 1'b0;
			case (state)
				IDLE: begin
					// count byte, zero means nothing to do
					if (rx_done && rx_data != 8'd0) begin
						words_left <= rx_data;
						byte_cnt   <= '0;
						mem_addr   <= '0;
						core_clear <= 1'b1;
						state      <= LOAD;
					end
				end
				LOAD: begin
					if (rx_done) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd3) begin
							mem_we <= 1'b1;
						end
					end
					// write cycle, step address
					if (mem_we) begin
						mem_addr   <= mem_addr + 1'b1;
						words_left <= words_left - 1'b1;
						if (words_left == 8'd1) begin
							run   <= 1'b1;
							state <= RUN;
						end
					end
				end
				RUN: begin
					// core reports halt, stop and report
					if (halt) begin
						run   <= 1'b0;
						state <= SEND_PC;
					end
				end
				SEND_PC: begin
					tx_start <= 1'b1;
					tx_data  <= pc;
					reg_sent <= 1'b0;
					state    <= WAIT_TX;
				end
				SEND_REG: begin
					// second byte already launched on entry
					reg_sent <= 1'b1;
					state    <= WAIT_TX;
				end
				default: begin
					if (tx_done) begin
						if (reg_sent) begin
							state <= IDLE;
						end else begin
							tx_start <= 1'b1;
							tx_data  <= reg1;
							state    <= SEND_REG;
						end
					end
				end
			endcase
		end
	end

	// bytes land lsb first
	always_ff @(posedge clk) begin
		if (state == LOAD && rx_done) begin
			word_sr <= {rx_data, word_sr[`DATA_LEN-1:8]};
		end
	end

	// memory is never written under a running core
	no_write_while_run: assert property (@(posedge clk) disable iff (reset)
		!(run && mem_we));

endmodule

`default_nettype wire

//--- source/inst_mem.sv
`default_nettype none

`include "mips_debug_cfg.svh"

module inst_mem import mips_pkg::*; (
	input  logic                 clk,
	input  logic                 we,
	input  logic [`ADDR_LEN-1:0] waddr,
	input  logic [`DATA_LEN-1:0] wdata,
	input  logic [`ADDR_LEN-1:0] raddr,
	output instr_t               rdata
);

	localparam int DEPTH = 2 ** `ADDR_LEN;

	logic [`DATA_LEN-1:0] mem [DEPTH];

	// loader port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// fetch port, same cycle as the pc
	assign rdata = mem[raddr];

endmodule

`default_nettype wire

//--- source/mips_core.sv
`default_nettype none

`include "mips_debug_cfg.svh"

module mips_core import mips_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 clear,
	input  logic                 run,
	input  instr_t               instr,
	output logic [`ADDR_LEN-1:0] fetch_addr,
	output logic [7:0]           pc,
	output logic [7:0]           reg1,
	output logic                 halt
);

	logic [`ADDR_LEN-1:0] pc_q;
	logic [`ADDR_LEN-1:0] pc_next;
	logic [`DATA_LEN-1:0] regs [`NUM_REGS];
	logic [`DATA_LEN-1:0] rs_val;
	logic [`DATA_LEN-1:0] rt_val;
	logic [`DATA_LEN-1:0] imm_ext;
	logic                 wr_en;
	logic [4:0]           wr_addr;
	logic [`DATA_LEN-1:0] wr_data;
	logic                 halt_next;
	logic                 step;

	assign fetch_addr = pc_q;
	assign pc         = 8'(pc_q);
	assign reg1       = regs[1][7:0];

	// advance only while running and not halted
	assign step = run && !halt;

	//////////////////////////////////////////////////////////////////////
	// decode and execute
	//////////////////////////////////////////////////////////////////////

	// operand read, both formats share rs and rt
	assign rs_val  = regs[instr.r.rs];
	assign rt_val  = regs[instr.r.rt];
	assign imm_ext = {{(`DATA_LEN - 16){instr.i.imm[15]}}, instr.i.imm};

	always_comb begin
		wr_en     = 1'b0;
		wr_addr   = instr.r.rd;
		wr_data   = rs_val + rt_val;
		pc_next   = pc_q + 1'b1;
		halt_next = 1'b0;
		case (instr.r.op)
			OP_RTYPE: begin
				case (instr.r.funct)
					FN_ADD: begin
						wr_en = 1'b1;
					end
					FN_SUB: begin
						wr_en   = 1'b1;
						wr_data = rs_val - rt_val;
					end
					// other functions fall through as no-op
					default: wr_en = 1'b0;
				endcase
			end
			OP_ADDI: begin
				// i-format target is rt
				wr_en   = 1'b1;
				wr_addr = instr.i.rt;
				wr_data = rs_val + imm_ext;
			end
			OP_BEQ: begin
				// offset relative to the next word
				if (rs_val == rt_val) begin
					pc_next = pc_q + 1'b1 + imm_ext[`ADDR_LEN-1:0];
				end
			end
			OP_HALT: begin
				// pc stays on the halt word
				pc_next   = pc_q;
				halt_next = 1'b1;
			end
			default: pc_next = pc_q + 1'b1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// state update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			pc_q <= '0;
			halt <= 1'b0;
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (step) begin
			pc_q <= pc_next;
			halt <= halt_next;
			// r0 is hardwired to zero
			if (wr_en && wr_addr != 5'd0) begin
				regs[wr_addr] <= wr_data;
			end
		end
	end

	// a halted core holds its pc on the halt word until the next load
	pc_frozen_on_halt: assert property (@(posedge clk) disable iff (reset)
		(halt && !clear) |=> ($stable(pc_q) && instr.r.op == OP_HALT));

endmodule

`default_nettype wire

//--- source/mips_debug_top.sv
`default_nettype none

`include "mips_debug_cfg.svh"

module mips_debug_top import mips_pkg::*; (
	input  logic clk100mhz,
	input  logic reset,
	input  logic rx_input,
	output logic tx_output
);

	// serial side
	logic [7:0]           rx_data;
	logic                 rx_done;
	logic [7:0]           tx_data;
	logic                 tx_start;
	logic                 tx_done;
	// loader to memory
	logic                 mem_we;
	logic [`ADDR_LEN-1:0] mem_addr;
	logic [`DATA_LEN-1:0] mem_wdata;
	// core control and status
	logic                 run;
	logic                 core_clear;
	logic                 halt;
	logic [7:0]           pc;
	logic [7:0]           reg1;
	// fetch
	logic [`ADDR_LEN-1:0] fetch_addr;
	instr_t               instr;

	uart_rx u_uart_rx (
		.clk     (clk100mhz),
		.reset   (reset),
		.rx_bit  (rx_input),
		.rx_data (rx_data),
		.rx_done (rx_done)
	);

	uart_tx u_uart_tx (
		.clk      (clk100mhz),
		.reset    (reset),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_bit   (tx_output),
		.tx_done  (tx_done)
	);

	debug_unit u_debug_unit (
		.clk        (clk100mhz),
		.reset      (reset),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.tx_done    (tx_done),
		.halt       (halt),
		.pc         (pc),
		.reg1       (reg1),
		.tx_start   (tx_start),
		.tx_data    (tx_data),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.run        (run),
		.core_clear (core_clear)
	);

	inst_mem u_inst_mem (
		.clk   (clk100mhz),
		.we    (mem_we),
		.waddr (mem_addr),
		.wdata (mem_wdata),
		.raddr (fetch_addr),
		.rdata (instr)
	);

	mips_core u_mips_core (
		.clk        (clk100mhz),
		.reset      (reset),
		.clear      (core_clear),
		.run        (run),
		.instr      (instr),
		.fetch_addr (fetch_addr),
		.pc         (pc),
		.reg1       (reg1),
		.halt       (halt)
	);

endmodule

`default_nettype wire

//--- testbench/tb_checker.sv
`default_nettype none

`include "mips_debug_cfg.svh"

module tb_checker (
	input  logic       clk,
	input  logic       tx_line,
	input  logic       test_start,
	input  logic [7:0] test_id,
	input  logic [7:0] exp_pc,
	input  logic [7:0] exp_reg,
	output int         done_count,
	output int         pass_count,
	output int         fail_count,
	output logic       hung
);

	localparam int BIT_CLKS   = `UART_CLKS_PER_BIT;
	localparam int WAIT_LIMIT = 20000;

	// receive status codes
	localparam logic [1:0] RX_OK      = 2'd0;
	localparam logic [1:0] RX_FRAMING = 2'd1;
	localparam logic [1:0] RX_TIMEOUT = 2'd2;

	//////////////////////////////////////////////////////////////////////
	// serial decoder, sampled on the falling clock edge
	//////////////////////////////////////////////////////////////////////

	task automatic wait_for_start_bit(output logic found);
		int n;
		found = 1'b0;
		n = 0;
		while (!found && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
			if (!tx_line) begin
				found = 1'b1;
			end
		end
	endtask

	task automatic receive_byte(output logic [7:0] data, output logic [1:0] status);
		logic found;
		data   = '0;
		status = RX_OK;
		wait_for_start_bit(found);
		if (!found) begin
			$display("no start bit on tx_output within %0d cycles", WAIT_LIMIT);
			status = RX_TIMEOUT;
		end else begin
			// middle of the start bit
			repeat (BIT_CLKS / 2) @(negedge clk);
			if (tx_line) begin
				$display("start bit on tx_output was only a glitch");
				status = RX_FRAMING;
			end else begin
				for (int b = 0; b < 8; b++) begin
					repeat (BIT_CLKS) @(negedge clk);
					data[b] = tx_line;
				end
				repeat (BIT_CLKS) @(negedge clk);
				if (!tx_line) begin
					$display("stop bit missing on tx_output");
					status = RX_FRAMING;
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// per-test comparison
	//////////////////////////////////////////////////////////////////////

	task automatic check_result();
		logic [7:0] want_pc;
		logic [7:0] want_reg;
		logic [7:0] got_pc;
		logic [7:0] got_reg;
		logic [1:0] st_pc;
		logic [1:0] st_reg;
		logic       good;
		want_pc  = exp_pc;
		want_reg = exp_reg;
		got_reg  = '0;
		st_reg   = RX_TIMEOUT;
		good     = 1'b1;
		// line must be idle before any answer
		if (!tx_line) begin
			$display("tx_output not idle at the start of test %0d", test_id);
			good = 1'b0;
		end
		receive_byte(got_pc, st_pc);
		if (st_pc != RX_TIMEOUT) begin
			receive_byte(got_reg, st_reg);
		end
		if (st_pc != RX_OK || st_reg != RX_OK) begin
			good = 1'b0;
		end
		if (st_pc == RX_TIMEOUT || st_reg == RX_TIMEOUT) begin
			hung = 1'b1;
		end
		if (st_pc == RX_OK && got_pc != want_pc) begin
			$display("CHECK FAILED at %0t: test %0d halt pc expected %02h, received %02h",
				$time, test_id, want_pc, got_pc);
			good = 1'b0;
		end
		if (st_reg == RX_OK && got_reg != want_reg) begin
			$display("CHECK FAILED at %0t: test %0d r1 expected %02h, received %02h",
				$time, test_id, want_reg, got_reg);
			good = 1'b0;
		end
		if (good) begin
			pass_count++;
			$display("test %0d passed", test_id);
		end else begin
			fail_count++;
			$display("test %0d failed", test_id);
		end
		done_count++;
	endtask

	initial begin
		done_count = 0;
		pass_count = 0;
		fail_count = 0;
		hung       = 1'b0;
		forever begin
			@(negedge clk);
			if (test_start) begin
				check_result();
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
`default_nettype none

`include "mips_debug_cfg.svh"

module tb_top;

	localparam int BIT_CLKS   = `UART_CLKS_PER_BIT;
	localparam int TEST_WORDS = 256;
	localparam int DONE_LIMIT = 60000;

	logic        clk;
	logic        reset;
	logic        rx_input;
	logic        tx_output;
	logic        test_start;
	logic [7:0]  test_id;
	logic [7:0]  exp_pc;
	logic [7:0]  exp_reg;
	int          done_count;
	int          pass_count;
	int          fail_count;
	logic        hung;
	logic        timed_out;

	// flat test image, see tests.txt for the column order
	logic [31:0] test_mem [TEST_WORDS];
	integer      seed;
	int          ptr;
	int          tests_run;

	//////////////////////////////////////////////////////////////////////
	// clock, DUT and checker
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
	end

	always begin
		#50 clk = ~clk;
	end

	mips_debug_top mips_debug_top_i (
		.clk100mhz (clk),
		.reset     (reset),
		.rx_input  (rx_input),
		.tx_output (tx_output)
	);

	tb_checker result_checker (
		.clk        (clk),
		.tx_line    (tx_output),
		.test_start (test_start),
		.test_id    (test_id),
		.exp_pc     (exp_pc),
		.exp_reg    (exp_reg),
		.done_count (done_count),
		.pass_count (pass_count),
		.fail_count (fail_count),
		.hung       (hung)
	);

	//////////////////////////////////////////////////////////////////////
	// serial driver
	//////////////////////////////////////////////////////////////////////

	// reset held for two cycles, line idle
	task automatic apply_reset();
		reset    <= 1'b1;
		rx_input <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
	endtask

	// start, eight bits lsb first, stop, then a random idle gap
	task automatic send_byte(input logic [7:0] data);
		logic [9:0] frame;
		int         gap;
		frame = {1'b1, data, 1'b0};
		for (int b = 0; b < 10; b++) begin
			rx_input <= frame[b];
			repeat (BIT_CLKS) @(posedge clk);
		end
		gap = $unsigned($random(seed)) % 32;
		repeat (gap) @(posedge clk);
	endtask

	// low byte goes out first
	task automatic send_word(input logic [31:0] word);
		send_byte(word[7:0]);
		send_byte(word[15:8]);
		send_byte(word[23:16]);
		send_byte(word[31:24]);
	endtask

	// count plus half of the first word, cut short by reset later
	task automatic send_partial_load(input int count, input logic [31:0] word);
		send_byte(8'(count));
		send_byte(word[7:0]);
		send_byte(word[15:8]);
	endtask

	// result counter from the checker, bounded
	task automatic wait_for_result(input int target);
		int n;
		n = 0;
		while (done_count < target && !hung && n < DONE_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (done_count < target && !hung) begin
			$display("timeout: no result for test %0d, debug unit stuck in state %s",
				test_id, mips_debug_top_i.u_debug_unit.state.name());
			timed_out = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [7:0] mode;
		int         count;
		reset      <= 1'b1;
		rx_input   <= 1'b1;
		test_start <= 1'b0;
		test_id    <= '0;
		exp_pc     <= '0;
		exp_reg    <= '0;
		seed      = 32'h0e0a73b3;
		ptr       = 0;
		tests_run = 0;
		timed_out = 1'b0;
		$readmemh("testbench/tests.txt", test_mem);
		apply_reset();

		// an id of zero ends the list
		while (ptr < TEST_WORDS - 3 && test_mem[ptr] != 32'h0 && !hung && !timed_out) begin
			mode  = test_mem[ptr + 1][7:0];
			count = int'(test_mem[ptr + 2][7:0]);
			// abandoned load, reset lands between bytes
			if (mode == 8'd1) begin
				send_partial_load(count, test_mem[ptr + 3]);
				apply_reset();
			end
			test_id    <= test_mem[ptr][7:0];
			exp_pc     <= test_mem[ptr + 3 + count][7:0];
			exp_reg    <= test_mem[ptr + 4 + count][7:0];
			test_start <= 1'b1;
			@(posedge clk);
			test_start <= 1'b0;
			// empty load, must not answer
			if (mode == 8'd2) begin
				send_byte(8'h00);
			end
			send_byte(8'(count));
			for (int w = 0; w < count; w++) begin
				send_word(test_mem[ptr + 3 + w]);
			end
			tests_run++;
			wait_for_result(tests_run);
			ptr = ptr + 5 + count;
		end

		$display("tests run %0d, passed %0d, failed %0d", tests_run, pass_count, fail_count);
		if (tests_run > 0 && fail_count == 0 && done_count == tests_run && !hung && !timed_out) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tests.txt
// id mode count word0 .. wordN-1 exp_pc exp_r1, all hex
// mode 0 plain load, 1 reset during a partial load first, 2 empty load first

// straight line, r1 = 5 + 7
01 00 04 20020005 20030007 00430820 fc000000 03 0c

// r3 = -10, write to r0 ignored, r1 = r3 - r2 + r0
02 00 06 20020003 2003fff6 2000004d 00620822 00200820 fc000000 05 f3

// count r1 up to r2 = 9, exit branch to halt at 4
03 00 05 20020009 20210001 10220001 1000fffd fc000000 04 09

// reload, r1 = r1 + 3 only holds with cleared registers
04 00 03 20050003 00250820 fc000000 02 03

// reset in the middle of the load, then the full load
05 01 02 2001002a fc000000 01 2a

// lone halt at address 0, after an empty load
06 02 01 fc000000 00 00

// end of list
00

//--- project.f
+incdir+source
source/mips_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/debug_unit.sv
source/inst_mem.sv
source/mips_core.sv
source/mips_debug_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the MIPS debug testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_top --Mdir "$BUILD_DIR" -o tb_sim -f project.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
	exit 0
fi

echo "pass message not found in $LOG"
exit 1
